//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // register and pc width
  localparam int unsigned xlen = 64;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = '0;

  // ebreak has one fixed encoding
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  // funct3 codes shared by op and op_imm
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 for op, alt selects sub
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op_imm = 7'b001_0011,
    opc_op     = 7'b011_0011,
    opc_lui    = 7'b011_0111,
    opc_auipc  = 7'b001_0111,
    opc_jal    = 7'b110_1111,
    opc_system = 7'b111_0011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_xor,
    alu_or,
    alu_and
  } alu_op_e;

  // one instruction word, four format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    // jump immediate bits as scrambled by the isa
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

  // decoded controls for one cycle
  typedef struct packed {
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            a_sel_pc;
    logic            a_zero;
    logic            b_sel_imm;
    logic            wb_link;
    logic            we;
    logic            jump;
    logic            valid;
  } ctrl_t;

  // one record per executed instruction
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic [4:0]      rd;
    logic            we;
    logic [xlen-1:0] wdata;
  } retire_t;

endpackage

`default_nettype wire

//--- design/rv_imem.sv
`default_nettype none

module rv_imem #(
  parameter int unsigned imem_depth = 64
) (
  input  logic                          clk,
  input  logic [63:0]                   addr,
  output rv_pkg::inst_t                 rdata,
  input  logic                          load_en,
  input  logic [$clog2(imem_depth)-1:0] load_addr,
  input  logic [31:0]                   load_data
);

  localparam int unsigned aw = $clog2(imem_depth);

  // program words, no reset
  logic [31:0] mem [imem_depth];

  // word index, upper address bits dropped so fetch wraps
  logic [aw-1:0] word_idx;

  assign word_idx = addr[aw+1:2];

  // asynchronous fetch
  assign rdata = mem[word_idx];

  // loader writes one word per edge
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::ctrl_t ctrl,
  input  logic [63:0]   target,
  output logic [63:0]   pc
);
  import rv_pkg::*;

  logic [63:0] next_pc;

  // jump target, fall through, or hold
  always_comb begin
    if (ctrl.valid && ctrl.jump) begin
      next_pc = target;
    end else if (ctrl.valid) begin
      next_pc = pc + 64'd4;
    end else begin
      // ebreak, illegal word or halted
      next_pc = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_ctrl.sv
`default_nettype none

module rv_ctrl (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::inst_t inst,
  output rv_pkg::ctrl_t ctrl,
  output logic          halted,
  output logic          illegal
);
  import rv_pkg::*;

  // encoding belongs to the subset
  logic    known;
  logic    is_ebreak;
  opcode_e opcode;

  assign opcode = opcode_e'(inst.r.opcode);

  always_comb begin
    ctrl      = '0;
    known     = 1'b1;
    is_ebreak = 1'b0;
    // register fields sit at the same bits in every format
    ctrl.rs1  = inst.r.rs1;
    ctrl.rs2  = inst.r.rs2;
    ctrl.rd   = inst.r.rd;
    case (opcode)
      opc_op_imm: begin
        ctrl.imm       = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
        ctrl.b_sel_imm = 1'b1;
        ctrl.we        = 1'b1;
        case (inst.i.funct3)
          f3_add:  ctrl.alu_op = alu_add;
          f3_slt:  ctrl.alu_op = alu_slt;
          f3_xor:  ctrl.alu_op = alu_xor;
          f3_or:   ctrl.alu_op = alu_or;
          f3_and:  ctrl.alu_op = alu_and;
          // shifts and sltiu not supported
          default: known = 1'b0;
        endcase
      end
      opc_op: begin
        ctrl.we = 1'b1;
        if (inst.r.funct7 == f7_base) begin
          case (inst.r.funct3)
            f3_add:  ctrl.alu_op = alu_add;
            f3_slt:  ctrl.alu_op = alu_slt;
            f3_xor:  ctrl.alu_op = alu_xor;
            f3_or:   ctrl.alu_op = alu_or;
            f3_and:  ctrl.alu_op = alu_and;
            default: known = 1'b0;
          endcase
        end else if (inst.r.funct7 == f7_alt && inst.r.funct3 == f3_add) begin
          ctrl.alu_op = alu_sub;
        end else begin
          known = 1'b0;
        end
      end
      opc_lui: begin
        // zero plus upper immediate
        ctrl.imm       = {{(xlen-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
        ctrl.a_zero    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.we        = 1'b1;
      end
      opc_auipc: begin
        ctrl.imm       = {{(xlen-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.we        = 1'b1;
      end
      opc_jal: begin
        // alu forms the target, rd gets the link
        ctrl.imm       = {{(xlen-21){inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                          inst.j.imm11, inst.j.imm10_1, 1'b0};
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.wb_link   = 1'b1;
        ctrl.we        = 1'b1;
        ctrl.jump      = 1'b1;
      end
      opc_system: begin
        // ebreak only, ecall and csr ops are illegal here
        if (inst == ebreak_word) begin
          is_ebreak = 1'b1;
        end else begin
          known = 1'b0;
        end
      end
      default: known = 1'b0;
    endcase
    // nothing executes while in reset
    ctrl.valid = ~rst & ~halted & known & ~is_ebreak;
  end

  // run/halt state, halt and illegal are sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (!halted && (is_ebreak || !known)) begin
        halted <= 1'b1;
      end
      if (!halted && !known) begin
        illegal <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [63:0] wdata,
  output logic [63:0] rdata1,
  output logic [63:0] rdata2
);

  // x1..x31, entry 0 never read
  logic [63:0] regs [32];

  // x0 reads zero, no bypass of same-cycle write
  assign rdata1 = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

  // writes to x0 dropped
  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_pkg::ctrl_t ctrl,
  input  logic [63:0]   pc,
  input  logic [63:0]   rdata1,
  input  logic [63:0]   rdata2,
  output logic [63:0]   result
);
  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  // a: zero for lui, pc for auipc and jal
  assign op_a = ctrl.a_zero   ? '0 :
                ctrl.a_sel_pc ? pc : rdata1;
  assign op_b = ctrl.b_sel_imm ? ctrl.imm : rdata2;

  always_comb begin
    case (ctrl.alu_op)
      alu_add: result = op_a + op_b;
      alu_sub: result = op_a - op_b;
      // signed compare, 0 or 1
      alu_slt: result = {63'd0, $signed(op_a) < $signed(op_b)};
      alu_xor: result = op_a ^ op_b;
      alu_or:  result = op_a | op_b;
      alu_and: result = op_a & op_b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

module rv_core #(
  parameter int unsigned imem_depth = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_en,
  input  logic [$clog2(imem_depth)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  output rv_pkg::retire_t               retire,
  output logic                          halted,
  output logic                          illegal
);
  import rv_pkg::*;

  logic [xlen-1:0] pc;
  inst_t           inst;
  ctrl_t           ctrl;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] result;
  logic [xlen-1:0] wdata;
  // register write only for an executing instruction
  logic            rf_we;

  rv_imem #(
    .imem_depth (imem_depth)
  ) i_imem (
    .clk       (clk),
    .addr      (pc),
    .rdata     (inst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  rv_ctrl i_ctrl (
    .clk     (clk),
    .rst     (rst),
    .inst    (inst),
    .ctrl    (ctrl),
    .halted  (halted),
    .illegal (illegal)
  );

  rv_regfile i_regfile (
    .clk    (clk),
    .rs1    (ctrl.rs1),
    .rs2    (ctrl.rs2),
    .rd     (ctrl.rd),
    .we     (rf_we),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  rv_alu i_alu (
    .ctrl   (ctrl),
    .pc     (pc),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .result (result)
  );

  // jal target comes out of the alu
  rv_pc_unit i_pc_unit (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .target (result),
    .pc     (pc)
  );

  // link value for jal, alu result otherwise
  assign wdata = ctrl.wb_link ? pc + 64'd4 : result;
  assign rf_we = ctrl.we & ctrl.valid;

  // trace of the instruction executing now
  always_comb begin
    retire.valid = ctrl.valid;
    retire.pc    = pc;
    retire.inst  = inst;
    retire.rd    = ctrl.rd;
    retire.we    = rf_we;
    retire.wdata = wdata;
  end

endmodule

`default_nettype wire

//--- verif/rv_core_tb_progs.svh
`ifndef RV_CORE_TB_PROGS_SVH
`define RV_CORE_TB_PROGS_SVH

// per-test tables, program words and the retire rows they must produce
localparam int n_tests   = 6;
localparam int max_words = 10;
localparam logic [31:0] ebreak_insn = 32'h0010_0073;

string       test_name   [n_tests];
int          prog_len    [n_tests];
logic [31:0] prog        [n_tests][max_words];
int          ret_len     [n_tests];
retire_t     exp_ret     [n_tests][max_words];
logic        exp_halted  [n_tests];
logic        exp_illegal [n_tests];

// encoders built from the isa formats
function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b001_0011};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b011_0011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

// imm is the byte offset, bit 0 dropped
function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
endfunction

function automatic logic [63:0] sext12(input logic [11:0] imm);
  return {{52{imm[11]}}, imm};
endfunction

// lui value, upper 20 bits then sign extension of bit 31
function automatic logic [63:0] upper20(input logic [19:0] imm);
  return {{32{imm[19]}}, imm, 12'h000};
endfunction

function automatic logic [63:0] slt64(input logic [63:0] x, input logic [63:0] y);
  return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
endfunction

// append one word, pc follows from its position
task automatic add_word(input int t, input logic [31:0] word, input logic retires,
                        input logic [4:0] rd, input logic [63:0] wdata);
  retire_t row;
  row.valid = 1'b1;
  row.pc    = 64'(prog_len[t] * 4);
  row.inst  = word;
  row.rd    = rd;
  row.we    = 1'b1;
  row.wdata = wdata;
  prog[t][prog_len[t]] = word;
  prog_len[t]++;
  if (retires) begin
    exp_ret[t][ret_len[t]] = row;
    ret_len[t]++;
  end
endtask

task automatic build_tests();
  logic [11:0] a;
  logic [11:0] b;
  logic [11:0] c;
  logic [11:0] d;
  logic [63:0] va;
  logic [63:0] vb;
  for (int t = 0; t < n_tests; t++) begin
    prog_len[t]    = 0;
    ret_len[t]     = 0;
    exp_halted[t]  = 1'b1;
    exp_illegal[t] = 1'b0;
  end
  a  = 12'($urandom);
  b  = 12'($urandom);
  c  = 12'($urandom);
  d  = 12'($urandom);
  va = sext12(a);
  vb = sext12(b);
  // immediate forms, random operands
  test_name[0] = "imm_ops";
  add_word(0, i_type(a, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, va);
  add_word(0, i_type(b, 5'd0, 3'b100, 5'd2), 1'b1, 5'd2, vb);
  add_word(0, i_type(c, 5'd1, 3'b110, 5'd3), 1'b1, 5'd3, va | sext12(c));
  add_word(0, i_type(d, 5'd1, 3'b111, 5'd4), 1'b1, 5'd4, va & sext12(d));
  add_word(0, i_type(b, 5'd1, 3'b010, 5'd5), 1'b1, 5'd5, slt64(va, vb));
  add_word(0, ebreak_insn, 1'b0, 5'd0, 64'd0);
  // register forms on x1, x2
  test_name[1] = "reg_ops";
  add_word(1, i_type(a, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, va);
  add_word(1, i_type(b, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, vb);
  add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd6), 1'b1, 5'd6, va + vb);
  add_word(1, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd7), 1'b1, 5'd7, va - vb);
  add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd8), 1'b1, 5'd8, va & vb);
  add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd9), 1'b1, 5'd9, va | vb);
  add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), 1'b1, 5'd10, va ^ vb);
  add_word(1, r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd11), 1'b1, 5'd11, slt64(va, vb));
  add_word(1, ebreak_insn, 1'b0, 5'd0, 64'd0);
  // x0 result shows on the trace but is not stored
  test_name[2] = "x0_write";
  add_word(2, i_type(12'h5a5, 5'd0, 3'b000, 5'd0), 1'b1, 5'd0, 64'h5a5);
  add_word(2, r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd5), 1'b1, 5'd5, 64'd0);
  add_word(2, ebreak_insn, 1'b0, 5'd0, 64'd0);
  // jal at pc 8 skips the word at 12
  test_name[3] = "upper_jump";
  add_word(3, u_type(20'h80001, 5'd1, 7'b011_0111), 1'b1, 5'd1, upper20(20'h80001));
  add_word(3, u_type(20'h00012, 5'd2, 7'b001_0111), 1'b1, 5'd2, 64'd4 + upper20(20'h00012));
  add_word(3, j_type(21'd8, 5'd3), 1'b1, 5'd3, 64'd12);
  add_word(3, i_type(12'd1, 5'd0, 3'b000, 5'd4), 1'b0, 5'd4, 64'd1);
  add_word(3, i_type(12'd7, 5'd0, 3'b000, 5'd5), 1'b1, 5'd5, 64'd7);
  add_word(3, ebreak_insn, 1'b0, 5'd0, 64'd0);
  // word after ebreak never executes
  test_name[4] = "ebreak_hold";
  add_word(4, i_type(12'd3, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 64'd3);
  add_word(4, ebreak_insn, 1'b0, 5'd0, 64'd0);
  add_word(4, i_type(12'd4, 5'd0, 3'b000, 5'd1), 1'b0, 5'd1, 64'd4);
  // custom-0 opcode is outside the subset
  test_name[5]   = "illegal_op";
  exp_illegal[5] = 1'b1;
  add_word(5, i_type(12'd1, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 64'd1);
  add_word(5, i_type(12'd2, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 64'd2);
  add_word(5, 32'h0000_000b, 1'b0, 5'd0, 64'd0);
  add_word(5, i_type(12'd3, 5'd0, 3'b000, 5'd3), 1'b0, 5'd3, 64'd3);
endtask

`endif

//--- verif/rv_core_tb.sv
`default_nettype none

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int imem_depth = 64;
  localparam int aw         = $clog2(imem_depth);
  // cycles watched after halt for stray retirements
  localparam int hold_cycles = 4;

  logic          clk;
  logic          rst;
  logic          load_en;
  logic [aw-1:0] load_addr;
  logic [31:0]   load_data;
  retire_t       retire;
  logic          halted;
  logic          illegal;

  int errors    = 0;
  int checks    = 0;
  int budget_ns = 0;

  `include "rv_core_tb_progs.svh"

  rv_core #(
    .imem_depth (imem_depth)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .retire    (retire),
    .halted    (halted),
    .illegal   (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // unused words hold a custom-0 opcode tagged with their index, so a stray fetch halts
  function automatic logic [31:0] fill_word(input int a);
    return {25'(a), 7'b000_1011};
  endfunction

  task automatic check_retire(input string name, input int row, input retire_t exp,
                              input retire_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      // fields: valid, pc, inst, rd, we, wdata
      $display("CHECK FAILED %s row %0d: expected %h, actual %h", name, row, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
    end
  endtask

  // whole memory under reset, once
  task automatic fill_memory();
    for (int a = 0; a < imem_depth; a++) begin
      @(posedge clk);
      rst       <= 1'b1;
      load_en   <= 1'b1;
      load_addr <= aw'(a);
      load_data <= fill_word(a);
    end
  endtask

  task automatic run_test(input int t);
    int got;
    int err0;
    err0 = errors;
    got  = 0;
    // 10 reset cycles, program words first then fill
    for (int c = 0; c < 10; c++) begin
      @(posedge clk);
      rst       <= 1'b1;
      load_en   <= 1'b1;
      load_addr <= aw'(c);
      load_data <= (c < prog_len[t]) ? prog[t][c] : fill_word(c);
    end
    @(negedge clk);
    check_flag(test_name[t], "retire.valid in reset", 1'b0, retire.valid);
    check_flag(test_name[t], "halted in reset", 1'b0, halted);
    check_flag(test_name[t], "illegal in reset", 1'b0, illegal);
    @(posedge clk);
    rst     <= 1'b0;
    load_en <= 1'b0;
    // mid-cycle sample equals what the next edge commits
    // one retirement per cycle from the first cycle out of reset
    while (!halted) begin
      @(negedge clk);
      if (retire.valid) begin
        if (got < ret_len[t]) begin
          check_retire(test_name[t], got, exp_ret[t][got], retire);
        end else begin
          errors++;
          $display("%s: unexpected retirement at pc %h", test_name[t], retire.pc);
        end
        got++;
      end else if (got < ret_len[t]) begin
        errors++;
        $display("%s: no retirement in the cycle for row %0d", test_name[t], got);
      end
    end
    if (got < ret_len[t]) begin
      errors++;
      $display("%s: core halted after %0d of %0d retirements", test_name[t], got,
               ret_len[t]);
    end
    // halted core must stay quiet
    repeat (hold_cycles) begin
      @(negedge clk);
      if (retire.valid) begin
        errors++;
        $display("%s: retirement at pc %h after halt", test_name[t], retire.pc);
      end
    end
    check_flag(test_name[t], "halted", exp_halted[t], halted);
    check_flag(test_name[t], "illegal", exp_illegal[t], illegal);
    $display("%-12s %s, %0d retired", test_name[t], (errors == err0) ? "ok" : "FAIL", got);
  endtask

  // watchdog, budget set once the tables exist
  initial begin
    wait (budget_ns != 0);
    #(budget_ns);
    $display("run timed out after %0d ns", budget_ns);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'h7afd7451));
    build_tests();
    budget_ns = imem_depth;
    for (int t = 0; t < n_tests; t++) begin
      budget_ns += 10 + prog_len[t] + 20;
    end
    budget_ns *= 100;
    fill_memory();
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+verif
design/rv_pkg.sv
design/rv_imem.sv
design/rv_pc_unit.sv
design/rv_ctrl.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_core.sv
verif/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_imem.sv
      - design/rv_pc_unit.sv
      - design/rv_ctrl.sv
      - design/rv_regfile.sv
      - design/rv_alu.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/rv_core_tb.sv
